/* compile.f */
+incdir+verilog
verilog/jag_ee_pkg.sv
verilog/jag_aud_pkg.sv
verilog/jag_clk_en.sv
verilog/jag_ee_array.sv
verilog/jag_ee_ctrl.sv
verilog/jag_i2s_rx.sv
verilog/jag_io_top.sv
verif/jag_io_chk.sv
verif/jag_io_tb.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0
TOP       ?= jag_io_tb
FILELIST  ?= compile.f
OBJDIR    ?= obj_dir
LOG       ?= sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, check $(LOG) for the pass message"
	@echo "  clean  remove build output and log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)
	./$(OBJDIR)/V$(TOP) > $(LOG) 2>&1; true
	@cat $(LOG)
	@grep -q "\*\* PASS \*\*" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)

/* verif/jag_io_tb.sv */
`timescale 1ns/100ps
`include "jag_io_defs.svh"

module jag_io_tb;

	import jag_ee_pkg::*;
	import jag_aud_pkg::*;

	localparam int CMD_US    = 3;                  // Worst EEPROM command incl. WRAL
	localparam int FRAME_US  = 3;                  // Frame with 20 bit words
	localparam int LIMIT_NS  = (40 * CMD_US + 30 * FRAME_US) * 1000 - 10000;

	logic        sys_clk = 1'b0;
	logic        xresetl = 1'b0;
	ee_pins_t    ee_pins = '0;
	i2s_pins_t   i2s = '{sck: 1'b0, ws: 1'b1, sd: 1'b0};
	logic        ee_do;
	aud_sample_t aud;
	logic        xvclk_ce, tlw, vid_ce;

	logic [31:0]           rng = 32'h59a3;
	logic [`JAG_EE_DW-1:0] model_mem [0:(1 << `JAG_EE_AW)-1];   // EEPROM model
	logic                  model_ewen = 1'b0;
	int                    val_errs = 0;       // Wrong values
	int                    other_errs = 0;     // Protocol and timing faults

	jag_io_top jag_io_top_i (
		.sys_clk    (sys_clk),
		.xresetl    (xresetl),
		.ee_pins_i  (ee_pins),
		.ee_do_o    (ee_do),
		.i2s_i      (i2s),
		.aud_o      (aud),
		.xvclk_ce_o (xvclk_ce),
		.tlw_o      (tlw),
		.vid_ce_o   (vid_ce)
	);

	initial begin
		forever #4 sys_clk = ~sys_clk;     // 8 ns period
	end

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	task automatic mismatch(input string name, input logic [31:0] exp, input logic [31:0] got);
		$display("FAIL %0t %s expected %h got %h", $time, name, exp, got);
		val_errs++;
	endtask

	task automatic fault(input string what);
		$display("ERROR at %0t: %s", $time, what);
		other_errs++;
	endtask

	// One sk period, low then high, returns 3 cycles after the rise
	task automatic clock_bit(input logic b);
		@(posedge sys_clk);
		ee_pins.sk <= 1'b0;
		ee_pins.di <= b;
		repeat (4) @(posedge sys_clk);
		ee_pins.sk <= 1'b1;
		repeat (3) @(posedge sys_clk);
	endtask

	task automatic send_bits(input logic [31:0] v, input int n);
		for (int i = n - 1; i >= 0; i--)
			clock_bit(v[i]);
	endtask

	task automatic ee_select;
		@(posedge sys_clk);
		ee_pins <= '{cs: 1'b1, sk: 1'b0, di: 1'b0};
		repeat (3) @(posedge sys_clk);
	endtask

	task automatic ee_deselect;
		@(posedge sys_clk);
		ee_pins <= '0;
		repeat (4) @(posedge sys_clk);
	endtask

	// Busy low right after the last bit, then back high
	task automatic wait_ready;
		int n;
		n = 0;
		@(negedge sys_clk);
		if (ee_do !== 1'b0)
			fault("EEPROM did not signal busy after a write command");
		while (ee_do !== 1'b1 && n < 400) begin
			@(negedge sys_clk);
			n++;
		end
		if (ee_do !== 1'b1)
			fault("EEPROM stayed busy, timed out waiting for ready");
	endtask

	// Shift one word out, dummy bit checked on the way
	task automatic ee_fetch(input logic [`JAG_EE_AW-1:0] a,
		output logic [`JAG_EE_DW-1:0] got);
		ee_select();
		send_bits({3'b110, a}, 9);
		@(negedge sys_clk);
		if (ee_do !== 1'b0)
			mismatch("ee_do_o dummy", 0, ee_do);
		for (int i = `JAG_EE_DW - 1; i >= 0; i--) begin
			clock_bit(1'b0);
			@(negedge sys_clk);
			got[i] = ee_do;
		end
		ee_deselect();
	endtask

	task automatic ee_read(input logic [`JAG_EE_AW-1:0] a);
		logic [`JAG_EE_DW-1:0] got;
		ee_fetch(a, got);
		if (got !== model_mem[a])
			mismatch($sformatf("ee_do_o word @%0d", a), model_mem[a], got);
	endtask

	task automatic ee_write(input logic [`JAG_EE_AW-1:0] a, input logic [`JAG_EE_DW-1:0] d);
		ee_select();
		send_bits({3'b101, a}, 9);
		send_bits(d, `JAG_EE_DW);
		wait_ready();
		if (model_ewen)
			model_mem[a] = d;
		ee_deselect();
	endtask

	task automatic ee_erase(input logic [`JAG_EE_AW-1:0] a);
		ee_select();
		send_bits({3'b111, a}, 9);
		wait_ready();
		if (model_ewen)
			model_mem[a] = `JAG_EE_ERASED;
		ee_deselect();
	endtask

	task automatic ee_eral;
		ee_select();
		send_bits(9'b100_100000, 9);
		wait_ready();
		if (model_ewen)
			for (int i = 0; i < (1 << `JAG_EE_AW); i++)
				model_mem[i] = `JAG_EE_ERASED;
		ee_deselect();
	endtask

	task automatic ee_wral(input logic [`JAG_EE_DW-1:0] d);
		ee_select();
		send_bits(9'b100_010000, 9);
		send_bits(d, `JAG_EE_DW);
		wait_ready();
		if (model_ewen)
			for (int i = 0; i < (1 << `JAG_EE_AW); i++)
				model_mem[i] = d;
		ee_deselect();
	endtask

	task automatic ee_set_ewen(input logic en);
		ee_select();
		send_bits(en ? 9'b100_110000 : 9'b100_000000, 9);
		model_ewen = en;
		ee_deselect();
	endtask

	// Data and ws change on the rising sck, RTL samples on falling
	task automatic i2s_slot(input logic sd, input logic ws);
		@(posedge sys_clk);
		i2s <= '{sck: 1'b1, ws: ws, sd: sd};
		repeat (4) @(posedge sys_clk);
		i2s.sck <= 1'b0;
		repeat (3) @(posedge sys_clk);
	endtask

	// n bits MSB first, ws switches on the last slot
	task automatic i2s_word(input logic [23:0] v, input int n, input logic ws, input logic ws_nxt);
		for (int i = n - 1; i >= 0; i--)
			i2s_slot(v[i], (i == 0) ? ws_nxt : ws);
	endtask

	function automatic logic [15:0] first16(input logic [23:0] v, input int n);
		logic [15:0] r;
		for (int i = 0; i < 16; i++)
			r[15 - i] = v[n - 1 - i];
		return r;
	endfunction

	task automatic check_enables;
		int last_x, last_v, nx, nv;
		last_x = -1;
		last_v = -1;
		nx = 0;
		nv = 0;
		for (int i = 0; i < 64; i++) begin
			@(negedge sys_clk);
			if (xvclk_ce === 1'b1) begin
				if (last_x >= 0 && i - last_x != `JAG_CE_PHASES)
					mismatch("xvclk_ce_o period", `JAG_CE_PHASES, i - last_x);
				last_x = i;
				nx++;
			end
			if (vid_ce === 1'b1) begin
				if (xvclk_ce !== 1'b1)
					fault("vid_ce_o pulsed without xvclk_ce_o");
				if (last_v >= 0 && i - last_v != 2 * `JAG_CE_PHASES)
					mismatch("vid_ce_o period", 2 * `JAG_CE_PHASES, i - last_v);
				last_v = i;
				nv++;
			end
		end
		if (nv < nx / 2 - 1 || nv > nx / 2 + 1)
			mismatch("vid_ce_o count", nx / 2, nv);
	endtask

	initial begin
		logic [23:0]           l, r;
		logic [15:0]           exp_l, exp_r;
		logic [`JAG_EE_DW-1:0] pwr_word;
		int                    n;
		// Reset, enables must stay quiet
		for (int i = 0; i < 8; i++) begin
			@(negedge sys_clk);
			if (i > 0 && {xvclk_ce, tlw, vid_ce} !== 3'b000)
				mismatch("enables in reset", 0, {xvclk_ce, tlw, vid_ce});
		end
		@(posedge sys_clk);
		xresetl <= 1'b1;
		check_enables();

		// Power up word must survive a write, then erase all
		ee_fetch(6'd5, pwr_word);
		model_mem[5] = pwr_word;
		ee_write(6'd5, ~pwr_word);                 // Ignored, EWEN clear
		ee_read(6'd5);
		ee_set_ewen(1'b1);
		ee_eral();
		for (int i = 0; i < 4; i++) begin
			rng = xorshift(rng);
			ee_read(rng[5:0]);
		end
		ee_read(6'd5);

		// Random words, each read back plus one random address
		for (int i = 0; i < 10; i++) begin
			rng = xorshift(rng);
			ee_write(rng[5:0], rng[31:16]);
			ee_read(rng[5:0]);
			rng = xorshift(rng);
			ee_read(rng[5:0]);
		end

		// Bulk and protection again
		rng = xorshift(rng);
		ee_write(rng[5:0], {1'b0, rng[30:16]});    // Never the erased value
		ee_erase(rng[5:0]);
		ee_read(rng[5:0]);
		rng = xorshift(rng);
		ee_wral(rng[23:8]);
		for (int i = 0; i < 3; i++) begin
			rng = xorshift(rng);
			ee_read(rng[5:0]);
		end
		ee_set_ewen(1'b0);
		ee_write(6'd9, ~model_mem[9]);
		ee_read(6'd9);

		// I2S, lead in slot moves the receiver onto a frame start
		exp_l = '0;
		exp_r = '0;
		i2s_word(24'd0, 1, 1'b1, 1'b0);
		for (int f = 0; f < 24; f++) begin
			n = (f >= 20) ? 20 : 16;               // Last few words run long
			rng = xorshift(rng);
			l = rng[23:0];
			rng = xorshift(rng);
			r = rng[23:0];
			i2s_word(l, n, 1'b0, 1'b1);
			i2s_word(r, n, 1'b1, 1'b0);
			if (f > 0 && aud !== {exp_l, exp_r})
				mismatch("aud_o", {exp_l, exp_r}, aud);
			exp_l = first16(l, n);
			exp_r = first16(r, n);
		end
		i2s_slot(1'b0, 1'b0);                      // Opens the next frame
		if (aud !== {exp_l, exp_r})
			mismatch("aud_o", {exp_l, exp_r}, aud);

		other_errs += jag_io_top_i.jag_io_chk_i.fails;   // Assertion failures
		$display("Done: %0d value errors, %0d other errors", val_errs, other_errs);
		if (val_errs == 0 && other_errs == 0)
			$display("** PASS **");
		else
			$display("** FAIL **");
		$finish;
	end

	// Watchdog
	initial begin
		#(LIMIT_NS);
		$display("Run did not finish within %0d ns", LIMIT_NS);
		$display("** FAIL **");
		$finish;
	end

endmodule

/* verif/jag_io_chk.sv */
`timescale 1ns/100ps

module jag_io_chk (
	input logic                 sys_clk,
	input logic                 xresetl,
	input jag_ee_pkg::ee_pins_t ee_pins_i,
	input logic                 ee_do_o,
	input logic                 xvclk_ce_o,
	input logic                 tlw_o,
	input logic                 vid_ce_o
);

	import jag_ee_pkg::*;

	int fails = 0;                         // Failed assertion count

	// Enables never overlap
	a_ce_tlw_excl: assert property (@(posedge sys_clk) disable iff (!xresetl)
		!(xvclk_ce_o && tlw_o))
		else begin
			$error("xvclk_ce_o and tlw_o high together");
			fails++;
		end

	// Divided enable only on a video enable
	a_vid_in_xv: assert property (@(posedge sys_clk) disable iff (!xresetl)
		vid_ce_o |-> xvclk_ce_o)
		else begin
			$error("vid_ce_o without xvclk_ce_o");
			fails++;
		end

	a_tlw_after_xv: assert property (@(posedge sys_clk) disable iff (!xresetl)
		xvclk_ce_o |-> ##3 tlw_o)
		else begin
			$error("tlw_o not 3 cycles after xvclk_ce_o");
			fails++;
		end

	// Deselected part reports ready one cycle on
	a_do_idle: assert property (@(posedge sys_clk) disable iff (!xresetl)
		!ee_pins_i.cs |=> ee_do_o)
		else begin
			$error("ee_do_o low while cs low");
			fails++;
		end

endmodule

bind jag_io_top jag_io_chk jag_io_chk_i (
	.sys_clk    (sys_clk),
	.xresetl    (xresetl),
	.ee_pins_i  (ee_pins_i),
	.ee_do_o    (ee_do_o),
	.xvclk_ce_o (xvclk_ce_o),
	.tlw_o      (tlw_o),
	.vid_ce_o   (vid_ce_o)
);

/* verilog/jag_io_top.sv */
`timescale 1ns/100ps
`include "jag_io_defs.svh"

module jag_io_top (
	input  logic                     sys_clk,
	input  logic                     xresetl,
	input  jag_ee_pkg::ee_pins_t     ee_pins_i,    // EEPROM cs, sk, di
	output logic                     ee_do_o,
	input  jag_aud_pkg::i2s_pins_t   i2s_i,
	output jag_aud_pkg::aud_sample_t aud_o,
	output logic                     xvclk_ce_o,
	output logic                     tlw_o,
	output logic                     vid_ce_o
);

	import jag_ee_pkg::*;
	import jag_aud_pkg::*;

	ee_wr_t                ee_wr;          // Controller to array
	logic [`JAG_EE_AW-1:0] ee_rd_addr;
	logic [`JAG_EE_DW-1:0] ee_rd_data;

	jag_clk_en jag_clk_en_i (
		.sys_clk    (sys_clk),
		.xresetl    (xresetl),
		.xvclk_ce_o (xvclk_ce_o),
		.tlw_o      (tlw_o),
		.vid_ce_o   (vid_ce_o)
	);

	jag_ee_ctrl jag_ee_ctrl_i (
		.sys_clk   (sys_clk),
		.xresetl   (xresetl),
		.pins_i    (ee_pins_i),
		.wr_o      (ee_wr),
		.rd_addr_o (ee_rd_addr),
		.rd_data_i (ee_rd_data),
		.do_o      (ee_do_o)
	);

	jag_ee_array jag_ee_array_i (
		.sys_clk   (sys_clk),
		.wr_i      (ee_wr),
		.rd_addr_i (ee_rd_addr),
		.rd_data_o (ee_rd_data)
	);

	jag_i2s_rx jag_i2s_rx_i (
		.sys_clk (sys_clk),
		.xresetl (xresetl),
		.i2s_i   (i2s_i),
		.aud_o   (aud_o)
	);

endmodule

/* verilog/jag_i2s_rx.sv */
`timescale 1ns/100ps
`include "jag_io_defs.svh"

module jag_i2s_rx (
	input  logic                     sys_clk,
	input  logic                     xresetl,
	input  jag_aud_pkg::i2s_pins_t   i2s_i,
	output jag_aud_pkg::aud_sample_t aud_o
);

	import jag_aud_pkg::*;

	aud_sample_t bufs;                     // Frame being assembled
	aud_sample_t aud_q;                    // Last complete frame

	logic                            sck_q;
	logic                            ws_q;         // ws at last falling edge
	logic                            side;         // 0 left, 1 right
	logic                            ws_next;      // ws change pending
	logic [$clog2(`JAG_AUD_W):0]     cnt;          // Top bit set means word full
	logic [$clog2(`JAG_AUD_W)-1:0]   bit_idx;
	logic                            sck_fall;
	logic                            sck_rise;

	assign sck_fall = ~i2s_i.sck & sck_q;
	assign sck_rise = i2s_i.sck & ~sck_q;
	assign bit_idx  = ~cnt[$clog2(`JAG_AUD_W)-1:0];   // MSB lands first

	always_ff @(posedge sys_clk) begin
		if (!xresetl) begin
			sck_q   <= i2s_i.sck;
			ws_q    <= i2s_i.ws;
			side    <= i2s_i.ws;
			ws_next <= 1'b0;
			cnt     <= '0;
			bufs    <= '0;
			aud_q   <= '0;
		end else begin
			sck_q <= i2s_i.sck;

			// Capture on falling sck
			if (sck_fall) begin
				if (!cnt[$clog2(`JAG_AUD_W)]) begin   // Drop overflow bits
					cnt <= cnt + 1;
					if (side)
						bufs.right[bit_idx] <= i2s_i.sd;
					else
						bufs.left[bit_idx]  <= i2s_i.sd;
				end
				ws_q <= i2s_i.ws;
				if (ws_q != i2s_i.ws)
					ws_next <= 1'b1;
			end

			// Channel switch one rising edge later
			if (sck_rise && ws_next) begin
				cnt     <= '0;
				side    <= ws_q;
				ws_next <= 1'b0;
				if (!ws_q) begin                       // New frame starts on left
					aud_q <= bufs;
					bufs  <= '0;
				end
			end
		end
	end

	assign aud_o = aud_q;

endmodule

/* verilog/jag_ee_ctrl.sv */
`timescale 1ns/100ps
`include "jag_io_defs.svh"

module jag_ee_ctrl (
	input  logic                  sys_clk,
	input  logic                  xresetl,
	input  jag_ee_pkg::ee_pins_t  pins_i,
	output jag_ee_pkg::ee_wr_t    wr_o,
	output logic [`JAG_EE_AW-1:0] rd_addr_o,
	input  logic [`JAG_EE_DW-1:0] rd_data_i,
	output logic                  do_o
);

	import jag_ee_pkg::*;

	ee_state_t state;
	ee_op_t    cmd_q;                      // Command being executed
	ee_op_t    op_dec;

	logic                            sk_q;
	logic                            ewen;            // Erase/write enable latch
	logic                            do_q;
	logic [$clog2(`JAG_EE_DW)-1:0]  cnt;             // Data bit count
	logic [`JAG_EE_AW+2:0]          ir;              // Start, opcode, address
	logic [`JAG_EE_AW+2:0]          ir_next;
	logic [`JAG_EE_DW-1:0]          dr;              // Data shift register
	logic [`JAG_EE_AW-1:0]          wr_addr;
	logic [`JAG_EE_DW-1:0]          wr_data;
	logic                            wr_loop;         // Sweep all words
	logic                            sk_rise;
	logic                            wr_busy;
	logic                            cmd_done;
	logic                            bulk;
	logic                            erase;

	assign sk_rise  = pins_i.sk & ~sk_q;
	assign ir_next  = {ir[`JAG_EE_AW+1:0], pins_i.di};
	assign wr_busy  = state[2];                       // Any WR_* state
	assign cmd_done = pins_i.cs && sk_rise && (state == ST_IDLE) && ir[`JAG_EE_AW+1];
	assign bulk     = (cmd_q == EE_ERAL) || (cmd_q == EE_WRAL);
	assign erase    = (cmd_q == EE_ERASE) || (cmd_q == EE_ERAL);

	// Opcode from the word as it will be after this shift
	always_comb begin
		case (ir_next[`JAG_EE_AW+1 -: 2])
			2'b10:   op_dec = EE_READ;
			2'b01:   op_dec = EE_WRITE;
			2'b11:   op_dec = EE_ERASE;
			default: begin
				// Extended opcodes live in the top address bits
				case (ir_next[`JAG_EE_AW-1 -: 2])
					2'b11:   op_dec = EE_EWEN;
					2'b00:   op_dec = EE_EWDS;
					2'b10:   op_dec = EE_ERAL;
					default: op_dec = EE_WRAL;
				endcase
			end
		endcase
	end

	always_ff @(posedge sys_clk) begin
		if (!xresetl) begin
			sk_q    <= 1'b0;
			state   <= ST_IDLE;
			cmd_q   <= EE_NONE;
			cnt     <= '0;
			ir      <= '0;
			do_q    <= 1'b1;
			ewen    <= 1'b0;
			wr_addr <= '0;
			wr_loop <= 1'b0;
		end else begin
			sk_q <= pins_i.sk;
			if (!pins_i.cs) begin
				// Deselect aborts everything
				state   <= ST_IDLE;
				cmd_q   <= EE_NONE;
				cnt     <= '0;
				ir      <= '0;
				do_q    <= 1'b1;
				wr_loop <= 1'b0;
			end else if (wr_busy) begin
				case (state)
					ST_WR_BEGIN: begin
						do_q    <= 1'b0;                  // Busy
						wr_addr <= bulk ? '0 : ir[`JAG_EE_AW-1:0];
						wr_loop <= bulk;
						state   <= ST_WR_WRITE;
					end
					ST_WR_WRITE: state <= ST_WR_LOOP;     // Array strobe here
					ST_WR_LOOP: begin
						if (!wr_loop || (&wr_addr)) begin
							state <= ST_WR_END;
						end else begin
							wr_addr <= wr_addr + 1;
							state   <= ST_WR_WRITE;
						end
					end
					default: begin
						do_q    <= 1'b1;                  // Ready
						state   <= ST_IDLE;
						cmd_q   <= EE_NONE;
						ir      <= '0;
						wr_loop <= 1'b0;
					end
				endcase
			end else if (sk_rise) begin
				case (state)
					ST_IDLE: begin
						ir <= ir_next;
						if (ir[`JAG_EE_AW+1]) begin        // Ninth bit completes it
							cmd_q <= op_dec;
							case (op_dec)
								EE_READ: begin
									do_q  <= 1'b0;       // Dummy bit
									state <= ST_READ;
								end
								EE_WRITE, EE_WRAL: state <= ST_DATA;
								EE_ERASE, EE_ERAL: state <= ST_WR_BEGIN;
								EE_EWEN: begin
									ewen <= 1'b1;
									ir   <= '0;
								end
								EE_EWDS: begin
									ewen <= 1'b0;
									ir   <= '0;
								end
								default: ir <= '0;
							endcase
						end
					end
					ST_DATA: begin
						cnt <= cnt + 1;
						if (cnt == '1)
							state <= ST_WR_BEGIN;              // 16th data bit in
					end
					ST_READ: do_q <= dr[`JAG_EE_DW-1];        // MSB first
					default: ;
				endcase
			end
		end
	end

	// Data path, no reset
	always_ff @(posedge sys_clk) begin
		if (cmd_done && (op_dec == EE_READ))
			dr <= rd_data_i;
		else if (pins_i.cs && sk_rise && (state == ST_DATA))
			dr <= {dr[`JAG_EE_DW-2:0], pins_i.di};
		else if (pins_i.cs && sk_rise && (state == ST_READ))
			dr <= {dr[`JAG_EE_DW-2:0], 1'b0};
		if (state == ST_WR_BEGIN)
			wr_data <= erase ? `JAG_EE_ERASED : dr;
	end

	assign rd_addr_o = ir_next[`JAG_EE_AW-1:0];   // Address of a completing READ
	assign wr_o      = '{we: ewen && (state == ST_WR_WRITE), addr: wr_addr, data: wr_data};
	assign do_o      = do_q;

endmodule

/* verilog/jag_ee_array.sv */
`timescale 1ns/100ps
`include "jag_io_defs.svh"

module jag_ee_array (
	input  logic                  sys_clk,
	input  jag_ee_pkg::ee_wr_t    wr_i,
	input  logic [`JAG_EE_AW-1:0] rd_addr_i,
	output logic [`JAG_EE_DW-1:0] rd_data_o
);

	import jag_ee_pkg::*;

	ee_wr_t wr;                            // Local copy of the write port

	// Cell contents undefined at power up
	logic [`JAG_EE_DW-1:0] mem [0:(1 << `JAG_EE_AW)-1];

	assign wr = wr_i;

	always_ff @(posedge sys_clk) begin
		if (wr.we)
			mem[wr.addr] <= wr.data;       // One word per strobe
	end

	// Read is combinational so READ loads the shifter on the command edge
	assign rd_data_o = mem[rd_addr_i];

endmodule

/* verilog/jag_clk_en.sv */
`timescale 1ns/100ps
`include "jag_io_defs.svh"

module jag_clk_en (
	input  logic sys_clk,
	input  logic xresetl,
	output logic xvclk_ce_o,               // Video clock enable
	output logic tlw_o,                    // Transparent latch write
	output logic vid_ce_o                  // Half rate video / CPU enable
);

	logic [$clog2(`JAG_CE_PHASES)-1:0] phase;
	logic xvclk_q;
	logic tlw_q;
	logic div_tog;                         // Extra divide by two

	// xvclk lands on phase 0, tlw on the last phase
	always_ff @(posedge sys_clk) begin
		if (!xresetl) begin
			phase   <= '0;
			xvclk_q <= 1'b0;
			tlw_q   <= 1'b0;
			div_tog <= 1'b0;
		end else begin
			if (phase == `JAG_CE_PHASES - 1)
				phase <= '0;
			else
				phase <= phase + 1;
			xvclk_q <= (phase == 0);
			tlw_q   <= (phase == `JAG_CE_PHASES - 1);   // Trails xvclk by 3
			if (tlw_q)
				div_tog <= ~div_tog;       // Low on first xvclk after reset
		end
	end

	assign xvclk_ce_o = xvclk_q;
	assign tlw_o      = tlw_q;
	assign vid_ce_o   = xvclk_q & div_tog; // Every second xvclk

endmodule

/* verilog/jag_aud_pkg.sv */
`include "jag_io_defs.svh"

package jag_aud_pkg;

	// I2S lines from the sound source
	typedef struct packed {
		logic sck;                         // Bit clock
		logic ws;                          // Word select, low is left
		logic sd;                          // Serial data, MSB first
	} i2s_pins_t;

	// One stereo sample
	typedef struct packed {
		logic [`JAG_AUD_W-1:0] left;
		logic [`JAG_AUD_W-1:0] right;
	} aud_sample_t;

endpackage

/* verilog/jag_ee_pkg.sv */
`include "jag_io_defs.svh"

package jag_ee_pkg;

	// Host side GPIO lines into the part
	typedef struct packed {
		logic cs;                          // Chip select, high active
		logic sk;                          // Serial clock
		logic di;                          // Serial data in
	} ee_pins_t;

	// Decoded instruction
	typedef enum logic [2:0] {
		EE_NONE  = 3'd0,
		EE_READ  = 3'd1,
		EE_WRITE = 3'd2,
		EE_ERASE = 3'd3,
		EE_EWEN  = 3'd4,
		EE_EWDS  = 3'd5,
		EE_ERAL  = 3'd6,
		EE_WRAL  = 3'd7
	} ee_op_t;

	// Bit 2 set marks the internal write sequence
	typedef enum logic [2:0] {
		ST_IDLE     = 3'b000,
		ST_DATA     = 3'b001,
		ST_READ     = 3'b010,
		ST_WR_BEGIN = 3'b100,
		ST_WR_WRITE = 3'b101,
		ST_WR_LOOP  = 3'b110,
		ST_WR_END   = 3'b111
	} ee_state_t;

	// Write port into the cell array
	typedef struct packed {
		logic                  we;
		logic [`JAG_EE_AW-1:0] addr;
		logic [`JAG_EE_DW-1:0] data;
	} ee_wr_t;

endpackage

/* verilog/jag_io_defs.svh */
`ifndef JAG_IO_DEFS_SVH
`define JAG_IO_DEFS_SVH

// Serial EEPROM geometry, 93C46 in 16 bit mode
`define JAG_EE_AW      6           // Word address bits
`define JAG_EE_DW      16          // Word width
`define JAG_EE_ERASED  16'hffff    // Erased cell reads back as ones

// Audio
`define JAG_AUD_W      16          // Bits kept per I2S channel

// sys_clk cycles per video clock period
`define JAG_CE_PHASES  4

`endif
